/* source/escape_pwd_pkg.sv */
`default_nettype none

package escape_pwd_pkg;

    // password word format, sign bit plus two excess-3 digits
    localparam int PWD_W     = 9;
    localparam int MAX_WORDS = 4;   // one word per hostage
    localparam int CNT_W     = 3;   // counts 0 to MAX_WORDS

    typedef logic signed [PWD_W-1:0] pwd_t;

    // word 0 sits in the low bits and goes out first
    typedef pwd_t [MAX_WORDS-1:0] pwd_set_t;

    typedef logic [CNT_W-1:0] cnt_t;

    localparam logic [3:0] EXCESS_BIAS = 4'd3;

endpackage

`default_nettype wire

/* source/pwd_collector.sv */
`default_nettype none

module pwd_collector import escape_pwd_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  pwd_t     in_data,
    input  logic     done,
    output logic     busy,
    output logic     set_valid,
    output pwd_set_t set_words,
    output cnt_t     set_cnt
);

    logic accept;

    assign accept = in_valid && !busy;

    // set_words/set_cnt double as the fill buffer, only meaningful with set_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            set_valid <= 1'b0;
            set_words <= '0;
            set_cnt   <= '0;
        end else begin
            set_valid <= 1'b0;
            if (set_valid) begin
                // sorter took the set on this edge, start clean
                set_words <= '0;
                set_cnt   <= '0;
            end else if (accept) begin
                for (int k = 0; k < MAX_WORDS; k++) begin
                    if (cnt_t'(k) == set_cnt)
                        set_words[k] <= in_data;
                end
                if (set_cnt < cnt_t'(MAX_WORDS))
                    set_cnt <= set_cnt + cnt_t'(1);
            end else if (!busy && set_cnt != '0) begin
                set_valid <= 1'b1;   // burst ended, in_valid sampled low
                busy      <= 1'b1;
            end
            if (done)
                busy <= 1'b0;        // last word is on the output
        end
    end

    // a burst never carries more than one word per hostage
    a_burst_len: assert property (
        @(posedge clk) disable iff (!rst_n)
        accept [*MAX_WORDS] |=> !in_valid
    );

endmodule

`default_nettype wire

/* source/pwd_sorter.sv */
`default_nettype none

module pwd_sorter import escape_pwd_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     set_valid,
    input  pwd_set_t set_words,
    input  cnt_t     set_cnt,
    output logic     sort_valid,
    output pwd_set_t sort_words,
    output cnt_t     sort_cnt
);

    pwd_t     w [MAX_WORDS];
    pwd_t     tmp;
    pwd_set_t sorted;

    // insertion network, word i sinks toward slot 0 while it is larger
    always_comb begin
        tmp = '0;
        for (int k = 0; k < MAX_WORDS; k++)
            w[k] = set_words[k];
        for (int i = 1; i < MAX_WORDS; i++) begin
            if (cnt_t'(i) < set_cnt) begin
                for (int j = MAX_WORDS - 1; j > 0; j--) begin
                    if (j <= i && w[j-1] < w[j]) begin
                        tmp    = w[j-1];
                        w[j-1] = w[j];
                        w[j]   = tmp;
                    end
                end
            end
        end
        for (int k = 0; k < MAX_WORDS; k++)
            sorted[k] = w[k];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sort_valid <= 1'b0;
        else
            sort_valid <= set_valid;
    end

    always_ff @(posedge clk) begin
        if (set_valid) begin
            sort_words <= sorted;
            sort_cnt   <= set_cnt;
        end
    end

endmodule

`default_nettype wire

/* source/pwd_decoder.sv */
`default_nettype none

module pwd_decoder import escape_pwd_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     sort_valid,
    input  pwd_set_t sort_words,
    input  cnt_t     sort_cnt,
    output logic     dec_valid,
    output pwd_set_t dec_words,
    output cnt_t     dec_cnt
);

    logic [PWD_W-1:0] mag [MAX_WORDS];
    pwd_set_t         decoded;

    // modulo 2^9 arithmetic, so a bad digit just wraps
    always_comb begin
        for (int k = 0; k < MAX_WORDS; k++) begin
            mag[k] = ({5'b0, sort_words[k][7:4]} - {5'b0, EXCESS_BIAS}) * 9'd10
                   + ({5'b0, sort_words[k][3:0]} - {5'b0, EXCESS_BIAS});
            if (!sort_cnt[0] && cnt_t'(k) < sort_cnt)
                decoded[k] = sort_words[k][PWD_W-1] ? -mag[k] : mag[k];
            else
                decoded[k] = sort_words[k];   // odd set or unused slot
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dec_valid <= 1'b0;
        else
            dec_valid <= sort_valid;
    end

    always_ff @(posedge clk) begin
        if (sort_valid) begin
            dec_words <= decoded;
            dec_cnt   <= sort_cnt;
        end
    end

endmodule

`default_nettype wire

/* source/pwd_centering.sv */
`default_nettype none

module pwd_centering import escape_pwd_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     dec_valid,
    input  pwd_set_t dec_words,
    input  cnt_t     dec_cnt,
    output logic     ctr_valid,
    output pwd_set_t ctr_words,
    output cnt_t     ctr_cnt
);

    pwd_t               w [MAX_WORDS];
    pwd_t               w_min;
    pwd_t               w_max;
    logic signed [PWD_W:0] sum;   // one extra bit so min+max cannot wrap
    logic signed [PWD_W:0] mid;
    pwd_set_t           centered;

    always_comb begin
        for (int k = 0; k < MAX_WORDS; k++)
            w[k] = dec_words[k];
        w_min = w[0];
        w_max = w[0];
        for (int k = 1; k < MAX_WORDS; k++) begin
            if (cnt_t'(k) < dec_cnt) begin
                if (w[k] < w_min)
                    w_min = w[k];
                if (w[k] > w_max)
                    w_max = w[k];
            end
        end
        sum = w_min + w_max;
        mid = sum / 10'sd2;             // truncates toward zero
        // midpoint always fits 9 bits
        for (int k = 0; k < MAX_WORDS; k++)
            centered[k] = w[k] - pwd_t'(mid);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ctr_valid <= 1'b0;
        else
            ctr_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ctr_words <= centered;
            ctr_cnt   <= dec_cnt;
        end
    end

endmodule

`default_nettype wire

/* source/pwd_smoother.sv */
`default_nettype none

module pwd_smoother import escape_pwd_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ctr_valid,
    input  pwd_set_t ctr_words,
    input  cnt_t     ctr_cnt,
    output logic     smo_valid,
    output pwd_set_t smo_words,
    output cnt_t     smo_cnt
);

    pwd_t                    s [MAX_WORDS];
    logic signed [PWD_W+1:0] acc;   // 2*a + b needs two extra bits
    pwd_set_t                smoothed;

    // running weighted average, each step feeds on the previous result
    always_comb begin
        acc  = '0;
        s[0] = ctr_words[0];
        for (int k = 1; k < MAX_WORDS; k++) begin
            acc  = 2 * s[k-1] + pwd_t'(ctr_words[k]);
            s[k] = pwd_t'(acc / 3);
        end
        for (int k = 0; k < MAX_WORDS; k++)
            smoothed[k] = s[k];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            smo_valid <= 1'b0;
        else
            smo_valid <= ctr_valid;
    end

    always_ff @(posedge clk) begin
        if (ctr_valid) begin
            smo_words <= smoothed;
            smo_cnt   <= ctr_cnt;
        end
    end

endmodule

`default_nettype wire

/* source/pwd_serializer.sv */
`default_nettype none

module pwd_serializer import escape_pwd_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     smo_valid,
    input  pwd_set_t smo_words,
    input  cnt_t     smo_cnt,
    output logic     out_valid,
    output pwd_t     out_data,
    output logic     done
);

    pwd_set_t lat_words;
    cnt_t     lat_cnt;
    cnt_t     idx;        // next word to send
    pwd_t     next_word;

    always_comb begin
        next_word = '0;
        for (int k = 0; k < MAX_WORDS; k++) begin
            if (cnt_t'(k) == idx)
                next_word = lat_words[k];
        end
    end

    always_ff @(posedge clk) begin
        if (smo_valid)
            lat_words <= smo_words;
    end

    // word 0 leaves straight from the input strobe, the rest from the latch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
            done      <= 1'b0;
            idx       <= '0;
            lat_cnt   <= '0;
        end else if (smo_valid) begin
            out_valid <= 1'b1;
            out_data  <= smo_words[0];
            done      <= (smo_cnt == cnt_t'(1));
            idx       <= cnt_t'(1);
            lat_cnt   <= smo_cnt;
        end else if (out_valid && idx != lat_cnt) begin
            out_data  <= next_word;
            done      <= (idx + cnt_t'(1) == lat_cnt);
            idx       <= idx + cnt_t'(1);
        end else begin
            out_valid <= 1'b0;
            out_data  <= '0;   // zero when idle
            done      <= 1'b0;
            idx       <= '0;
        end
    end

    // busy upstream must keep sets from overlapping here
    a_no_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        smo_valid |-> !out_valid
    );

endmodule

`default_nettype wire

/* source/pwd_processor.sv */
`default_nettype none

module pwd_processor import escape_pwd_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  pwd_t in_data,
    output logic busy,
    output logic out_valid,
    output pwd_t out_data
);

    logic     set_valid, sort_valid, dec_valid, ctr_valid, smo_valid;
    pwd_set_t set_words, sort_words, dec_words, ctr_words, smo_words;
    cnt_t     set_cnt, sort_cnt, dec_cnt, ctr_cnt, smo_cnt;
    logic     done;

    pwd_collector u_collector (
        .clk       (clk),       .rst_n     (rst_n),
        .in_valid  (in_valid),  .in_data   (in_data),
        .done      (done),      .busy      (busy),
        .set_valid (set_valid), .set_words (set_words), .set_cnt (set_cnt)
    );

    pwd_sorter u_sorter (
        .clk        (clk),        .rst_n      (rst_n),
        .set_valid  (set_valid),  .set_words  (set_words),  .set_cnt  (set_cnt),
        .sort_valid (sort_valid), .sort_words (sort_words), .sort_cnt (sort_cnt)
    );

    // decode only touches even-sized sets
    pwd_decoder u_decoder (
        .clk        (clk),        .rst_n      (rst_n),
        .sort_valid (sort_valid), .sort_words (sort_words), .sort_cnt (sort_cnt),
        .dec_valid  (dec_valid),  .dec_words  (dec_words),  .dec_cnt  (dec_cnt)
    );

    pwd_centering u_centering (
        .clk       (clk),       .rst_n     (rst_n),
        .dec_valid (dec_valid), .dec_words (dec_words), .dec_cnt (dec_cnt),
        .ctr_valid (ctr_valid), .ctr_words (ctr_words), .ctr_cnt (ctr_cnt)
    );

    pwd_smoother u_smoother (
        .clk       (clk),       .rst_n     (rst_n),
        .ctr_valid (ctr_valid), .ctr_words (ctr_words), .ctr_cnt (ctr_cnt),
        .smo_valid (smo_valid), .smo_words (smo_words), .smo_cnt (smo_cnt)
    );

    pwd_serializer u_serializer (
        .clk       (clk),       .rst_n     (rst_n),
        .smo_valid (smo_valid), .smo_words (smo_words), .smo_cnt (smo_cnt),
        .out_valid (out_valid), .out_data  (out_data),  .done    (done)
    );

endmodule

`default_nettype wire

/* verif/pwd_ref_model.svh */
`ifndef PWD_REF_MODEL_SVH
`define PWD_REF_MODEL_SVH

// low 9 bits read back as a signed word
function automatic int wrap9(input int v);
    int r;
    r = v & 511;
    if (r > 255)
        r = r - 512;
    return r;
endfunction

// sort, decode on even count, center, smooth; unused input slots are zero
function automatic void model_set(input int in_w [4], input int cnt, output int res [4]);
    int w [4];
    int t, hi, lo, mag, mn, mx, mid;
    for (int k = 0; k < 4; k++)
        w[k] = in_w[k];
    for (int i = 1; i < cnt; i++) begin
        for (int j = i; j > 0 && w[j-1] < w[j]; j--) begin   // largest first
            t      = w[j-1];
            w[j-1] = w[j];
            w[j]   = t;
        end
    end
    if (cnt % 2 == 0) begin
        for (int k = 0; k < cnt; k++) begin
            hi   = (w[k] >> 4) & 15;
            lo   = w[k] & 15;
            mag  = (hi - 3) * 10 + (lo - 3);
            w[k] = (w[k] < 0) ? wrap9(-mag) : wrap9(mag);   // bit 8 is the sign
        end
    end
    mn = w[0];
    mx = w[0];
    for (int k = 1; k < cnt; k++) begin
        if (w[k] < mn)
            mn = w[k];
        if (w[k] > mx)
            mx = w[k];
    end
    mid = (mn + mx) / 2;   // truncates toward zero
    for (int k = 0; k < 4; k++)
        w[k] = wrap9(w[k] - mid);
    for (int k = 1; k < 4; k++)
        w[k] = wrap9((2 * w[k-1] + w[k]) / 3);
    res = w;
endfunction

`endif

/* verif/tb_pwd_processor.sv */
`default_nettype none

module tb_pwd_processor;

    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    logic signed [8:0] in_data;
    logic              busy;
    logic              out_valid;
    logic signed [8:0] out_data;

    logic [31:0] lfsr_q = 32'hbde9;
    int          value_errs = 0;
    int          proto_errs = 0;   // timeouts and stray outputs
    int          exp_q [$];

    `include "pwd_ref_model.svh"

    pwd_processor UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic out_bit;
        out_bit = lfsr_q[0];
        lfsr_q  = lfsr_q >> 1;
        if (out_bit)
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        return out_bit;
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
            v = (v << 1) | int'(lfsr_step());
        return v;
    endfunction

    // sign plus two digits in 3..12
    function automatic int excess3_word();
        int sign, hi, lo;
        sign = take_bits(1);
        hi   = 3 + take_bits(4) % 10;
        lo   = 3 + take_bits(4) % 10;
        return wrap9(sign * 256 + hi * 16 + lo);
    endfunction

    task automatic check_value(input string name, input int exp, input int got);
        assert (got == exp)
        else begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, got);
            value_errs++;
        end
    endtask

    // junk is only offered while busy, so the collector must drop it
    task automatic drive_idle(input bit junk);
        in_valid = junk && busy;
        in_data  = (junk && busy) ? take_bits(9) : 0;
    endtask

    task automatic run_burst(input string name, input int len, input int words [4],
                             input bit junk);
        int w_in [4];
        int res [4];
        int n;
        int seen;
        for (int k = 0; k < 4; k++)
            w_in[k] = (k < len) ? words[k] : 0;
        model_set(w_in, len, res);
        for (int k = 0; k < len; k++)
            exp_q.push_back(res[k]);
        for (int k = 0; k < len; k++) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_data  = words[k][8:0];
        end
        @(negedge clk);
        in_valid = 1'b0;   // edge T samples this
        in_data  = '0;
        n = 0;
        while (!out_valid && n < 20) begin
            @(negedge clk);
            n++;
            check_value($sformatf("%s busy while waiting", name), 1, int'(busy));
            drive_idle(junk);
        end
        assert (out_valid)
        else begin
            $display("%s: no output word appeared within 20 cycles", name);
            proto_errs++;
        end
        check_value($sformatf("%s latency", name), 5, n - 1);
        seen = 0;
        while (out_valid && seen < 8) begin
            assert (exp_q.size() > 0)
            else begin
                $display("%s: output word arrived with nothing expected", name);
                proto_errs++;
            end
            if (exp_q.size() > 0)
                check_value($sformatf("%s word %0d", name, seen), exp_q.pop_front(),
                            int'(out_data));
            check_value($sformatf("%s busy word %0d", name, seen), 1, int'(busy));
            seen++;
            @(negedge clk);
            drive_idle(junk);
        end
        check_value($sformatf("%s length", name), len, seen);
        check_value($sformatf("%s busy after set", name), 0, int'(busy));
        check_value($sformatf("%s idle data", name), 0, int'(out_data));
        exp_q.delete();   // a short set must not leak into the next one
        in_valid = 1'b0;
    endtask

    initial begin
        int words [4];
        int len;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("reset busy", 0, int'(busy));
            check_value("reset out_valid", 0, int'(out_valid));
            check_value("reset out_data", 0, int'(out_data));
        end
        for (len = 1; len <= 4; len++) begin
            for (int k = 0; k < 4; k++)
                words[k] = wrap9(take_bits(9));
            run_burst($sformatf("length %0d", len), len, words, 1'b0);
        end
        // same coded words, decoded only when the count is even
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++)
                words[k] = excess3_word();
            run_burst($sformatf("xs3 set %0d even", r), 4, words, 1'b0);
            run_burst($sformatf("xs3 set %0d odd", r), 3, words, 1'b0);
            run_burst($sformatf("xs3 set %0d pair", r), 2, words, 1'b1);
            run_burst($sformatf("xs3 set %0d single", r), 1, words, 1'b1);
        end
        for (int b = 0; b < 60; b++) begin
            len = 1 + take_bits(2);
            for (int k = 0; k < 4; k++)
                words[k] = wrap9(take_bits(9));
            repeat (take_bits(2)) @(negedge clk);   // idle gap
            run_burst($sformatf("random %0d", b), len, words, take_bits(1) == 1);
        end
        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs + proto_errs == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* pwd_processor.f */
+incdir+verif
source/escape_pwd_pkg.sv
source/pwd_collector.sv
source/pwd_sorter.sv
source/pwd_decoder.sv
source/pwd_centering.sv
source/pwd_smoother.sv
source/pwd_serializer.sv
source/pwd_processor.sv
verif/tb_pwd_processor.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the password processor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pwd_processor -f pwd_processor.f -o sim_pwd

./obj_dir/sim_pwd | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
